/* hdl/zigzag_pkg.sv */
// Block geometry constants, zigzag order tables and forward and inverse index functions
package zigzag_pkg;

    // Block geometry
    localparam int block_size = 64;
    localparam int row_size   = 8;
    localparam int pair_beats = block_size / 2;

    // Raster position visited at each zigzag index
    localparam logic [5:0] zz_raster [64] = '{
        6'd0,  6'd1,  6'd8,  6'd16, 6'd9,  6'd2,  6'd3,  6'd10,
        6'd17, 6'd24, 6'd32, 6'd25, 6'd18, 6'd11, 6'd4,  6'd5,
        6'd12, 6'd19, 6'd26, 6'd33, 6'd40, 6'd48, 6'd41, 6'd34,
        6'd27, 6'd20, 6'd13, 6'd6,  6'd7,  6'd14, 6'd21, 6'd28,
        6'd35, 6'd42, 6'd49, 6'd56, 6'd57, 6'd50, 6'd43, 6'd36,
        6'd29, 6'd22, 6'd15, 6'd23, 6'd30, 6'd37, 6'd44, 6'd51,
        6'd58, 6'd59, 6'd52, 6'd45, 6'd38, 6'd31, 6'd39, 6'd46,
        6'd53, 6'd60, 6'd61, 6'd54, 6'd47, 6'd55, 6'd62, 6'd63
    };

    // Zigzag index of each raster position as the inverse of zz_raster
    localparam logic [5:0] zz_index [64] = '{
        6'd0,  6'd1,  6'd5,  6'd6,  6'd14, 6'd15, 6'd27, 6'd28,
        6'd2,  6'd4,  6'd7,  6'd13, 6'd16, 6'd26, 6'd29, 6'd42,
        6'd3,  6'd8,  6'd12, 6'd17, 6'd25, 6'd30, 6'd41, 6'd43,
        6'd9,  6'd11, 6'd18, 6'd24, 6'd31, 6'd40, 6'd44, 6'd53,
        6'd10, 6'd19, 6'd23, 6'd32, 6'd39, 6'd45, 6'd52, 6'd54,
        6'd20, 6'd22, 6'd33, 6'd38, 6'd46, 6'd51, 6'd55, 6'd60,
        6'd21, 6'd34, 6'd37, 6'd47, 6'd50, 6'd56, 6'd59, 6'd61,
        6'd35, 6'd36, 6'd48, 6'd49, 6'd57, 6'd58, 6'd62, 6'd63
    };

    // Raster position to zigzag index
    function automatic logic [5:0] en_zigzag(input logic [5:0] pos);
        return zz_index[pos];
    endfunction

    // Zigzag index to raster position
    function automatic logic [5:0] de_zigzag(input logic [5:0] idx);
        return zz_raster[idx];
    endfunction

endpackage

/* hdl/quant_pkg.sv */
// Quantizer data widths, multiplier latency and the luminance quantization table
package quant_pkg;

    // Input DCT coefficient width
    localparam int dw = 15;

    // Unsigned reciprocal factor width
    localparam int mw = 13;

    // Quantized output width
    localparam int qw = 11;

    // Factors are 2^frac_bits over the table entry
    localparam int frac_bits = mw - 1;

    // Full product width
    localparam int pw = dw + mw;

    // Register stages in the multiplier
    localparam int mult_stages = 4;

    // Standard luminance table at quality 50, raster order
    localparam logic [7:0] luma_table [64] = '{
        8'd16, 8'd11, 8'd10, 8'd16, 8'd24,  8'd40,  8'd51,  8'd61,
        8'd12, 8'd12, 8'd14, 8'd19, 8'd26,  8'd58,  8'd60,  8'd55,
        8'd14, 8'd13, 8'd16, 8'd24, 8'd40,  8'd57,  8'd69,  8'd56,
        8'd14, 8'd17, 8'd22, 8'd29, 8'd51,  8'd87,  8'd80,  8'd62,
        8'd18, 8'd22, 8'd37, 8'd56, 8'd68,  8'd109, 8'd103, 8'd77,
        8'd24, 8'd35, 8'd55, 8'd64, 8'd81,  8'd104, 8'd113, 8'd92,
        8'd49, 8'd64, 8'd78, 8'd87, 8'd103, 8'd121, 8'd120, 8'd101,
        8'd72, 8'd92, 8'd95, 8'd98, 8'd112, 8'd100, 8'd103, 8'd99
    };

endpackage

/* hdl/zigzag_buffer.sv */
// Zigzag reorder buffer with write and read phases and paired read positions
module zigzag_buffer
    import zigzag_pkg::*, quant_pkg::*;
(
    input  logic                 clk,
    input  logic                 resetn,
    input  logic signed [dw-1:0] di0,
    input  logic signed [dw-1:0] di1,
    input  logic signed [dw-1:0] di2,
    input  logic signed [dw-1:0] di3,
    input  logic signed [dw-1:0] di4,
    input  logic signed [dw-1:0] di5,
    input  logic signed [dw-1:0] di6,
    input  logic signed [dw-1:0] di7,
    input  logic                 di_valid,
    input  logic [2:0]           di_cnt,
    output logic                 di_hold,
    input  logic                 hold,
    output logic                 rd_en,
    output logic [5:0]           rd_pos0,
    output logic [5:0]           rd_pos1,
    output logic signed [dw-1:0] rd_data0,
    output logic signed [dw-1:0] rd_data1
);

    // Memory holds the block in zigzag order
    logic signed [dw-1:0] mem [block_size];
    logic signed [dw-1:0] di_row [row_size];
    logic                 read_phase;
    logic [4:0]           rd_cnt;
    logic                 wr_en;
    logic [5:0]           rd_idx0;
    logic [5:0]           rd_idx1;

    assign di_row[0] = di0;
    assign di_row[1] = di1;
    assign di_row[2] = di2;
    assign di_row[3] = di3;
    assign di_row[4] = di4;
    assign di_row[5] = di5;
    assign di_row[6] = di6;
    assign di_row[7] = di7;

    // Rows are only taken during the write phase
    assign wr_en   = di_valid & ~read_phase;
    assign rd_en   = read_phase & ~hold;
    assign di_hold = read_phase;

    // Last row starts the read phase and the last pair ends it
    always_ff @(posedge clk) begin
        if (!resetn) begin
            read_phase <= 1'b0;
            rd_cnt     <= '0;
        end else if (rd_en) begin
            rd_cnt <= rd_cnt + 5'd1;
            if (rd_cnt == 5'(pair_beats - 1)) begin
                read_phase <= 1'b0;
            end
        end else if (wr_en && di_cnt == 3'(row_size - 1)) begin
            read_phase <= 1'b1;
        end
    end

    // Scatter each row to the zigzag slots of its raster positions
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int j = 0; j < row_size; j++) begin
                mem[en_zigzag(6'(di_cnt * row_size + j))] <= di_row[j];
            end
        end
    end

    // Read side walks the memory linearly with two entries per beat
    assign rd_idx0  = {rd_cnt, 1'b0};
    assign rd_idx1  = {rd_cnt, 1'b1};
    assign rd_data0 = mem[rd_idx0];
    assign rd_data1 = mem[rd_idx1];

    // Raster positions for the factor lookup
    assign rd_pos0 = de_zigzag(rd_idx0);
    assign rd_pos1 = de_zigzag(rd_idx1);

endmodule

/* hdl/quant_tables.sv */
// Reciprocal quantization factor ROM with two registered read ports
module quant_tables
    import zigzag_pkg::*, quant_pkg::*;
(
    input  logic          clk,
    input  logic          re,
    input  logic [5:0]    pos0,
    input  logic [5:0]    pos1,
    output logic [mw-1:0] factor0,
    output logic [mw-1:0] factor1
);

    // One factor per raster position
    logic [mw-1:0] rom [block_size];

    // Each entry is 2^frac_bits over the table value, rounded down
    // so multiplying and shifting right by frac_bits divides by the entry
    for (genvar i = 0; i < block_size; i++) begin : g_rom
        assign rom[i] = mw'((1 << frac_bits) / luma_table[i]);
    end

    // Registered reads; factors hold their value while the pipeline stalls
    always_ff @(posedge clk) begin
        if (re) begin
            factor0 <= rom[pos0];
            factor1 <= rom[pos1];
        end
    end

endmodule

/* hdl/quant_mult.sv */
// Four-stage pipelined signed by unsigned multiplier with valid tracking
module quant_mult
    import quant_pkg::*;
(
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 en,
    input  logic signed [dw-1:0] a,
    input  logic [mw-1:0]        b,
    input  logic                 in_valid,
    output logic signed [pw-1:0] p,
    output logic                 out_valid
);

    // Stage 1 operands
    logic signed [dw-1:0]   a_r;
    logic [mw-1:0]          b_r;

    // Stage 2 partial products with b split at bit 7
    logic signed [dw+7:0]   pp_lo;
    logic signed [dw+5:0]   pp_hi;
    logic signed [pw-1:0]   pp_lo_ext;
    logic signed [pw-1:0]   pp_hi_ext;

    // Stage 3 sum
    logic signed [pw-1:0]   sum;

    logic [mult_stages-1:0] vld;

    // Sign extension to product width
    assign pp_lo_ext = pp_lo;
    assign pp_hi_ext = pp_hi;

    always_ff @(posedge clk) begin
        if (en) begin
            a_r <= a;
            b_r <= b;
            // Zero-extended factor halves keep the multiply signed
            pp_lo <= a_r * $signed({1'b0, b_r[6:0]});
            pp_hi <= a_r * $signed({1'b0, b_r[mw-1:7]});
            sum   <= (pp_hi_ext <<< 7) + pp_lo_ext;
            p     <= sum;
        end
    end

    // Valid bit moves one stage per enabled edge along with the data
    always_ff @(posedge clk) begin
        if (!resetn) begin
            vld <= '0;
        end else if (en) begin
            vld <= {vld[mult_stages-2:0], in_valid};
        end
    end

    assign out_valid = vld[mult_stages-1];

endmodule

/* hdl/quant_result.sv */
// Product scaling, saturation to output width and output pair counter
module quant_result
    import quant_pkg::*;
(
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 hold,
    input  logic signed [pw-1:0] prod0,
    input  logic signed [pw-1:0] prod1,
    input  logic                 prod_valid,
    output logic signed [qw-1:0] q0,
    output logic signed [qw-1:0] q1,
    output logic                 q_valid,
    output logic [4:0]           q_cnt
);

    // Scale down by frac_bits and clamp into qw bits
    function automatic logic signed [qw-1:0] scale_sat(input logic signed [pw-1:0] prod);
        logic signed [pw-frac_bits-1:0] scaled;
        logic                           fits;
        // Dropping low bits of a two's complement value floors it
        scaled = prod[pw-1:frac_bits];
        // In range when all bits above the output sign match it
        fits = (&scaled[pw-frac_bits-1:qw-1]) | ~(|scaled[pw-frac_bits-1:qw-1]);
        if (fits) begin
            return scaled[qw-1:0];
        end else if (scaled[pw-frac_bits-1]) begin
            return {1'b1, {(qw-1){1'b0}}};
        end else begin
            return {1'b0, {(qw-1){1'b1}}};
        end
    endfunction

    assign q0      = scale_sat(prod0);
    assign q1      = scale_sat(prod1);
    assign q_valid = prod_valid;

    // Pair index within the block wrapping after the last pair
    always_ff @(posedge clk) begin
        if (!resetn) begin
            q_cnt <= '0;
        end else if (prod_valid && !hold) begin
            q_cnt <= q_cnt + 5'd1;
        end
    end

endmodule

/* hdl/quant.sv */
// Quantizer top with zigzag buffer, factor tables, two multipliers and result stage
module quant
    import quant_pkg::*;
(
    input  logic                 clk,
    input  logic                 resetn,
    input  logic signed [dw-1:0] di0,
    input  logic signed [dw-1:0] di1,
    input  logic signed [dw-1:0] di2,
    input  logic signed [dw-1:0] di3,
    input  logic signed [dw-1:0] di4,
    input  logic signed [dw-1:0] di5,
    input  logic signed [dw-1:0] di6,
    input  logic signed [dw-1:0] di7,
    input  logic                 di_valid,
    input  logic [2:0]           di_cnt,
    output logic                 di_hold,
    output logic signed [qw-1:0] q0,
    output logic signed [qw-1:0] q1,
    output logic                 q_valid,
    input  logic                 q_hold,
    output logic [4:0]           q_cnt
);

    logic                 rd_en;
    logic [5:0]           rd_pos0;
    logic [5:0]           rd_pos1;
    logic signed [dw-1:0] rd_data0;
    logic signed [dw-1:0] rd_data1;
    logic [mw-1:0]        factor0;
    logic [mw-1:0]        factor1;

    // Coefficients registered to line up with the table read
    logic signed [dw-1:0] al_data0;
    logic signed [dw-1:0] al_data1;
    logic                 al_valid;

    logic                 mult_en;
    logic signed [pw-1:0] prod0;
    logic signed [pw-1:0] prod1;
    logic                 prod_valid;

    // Whole read and multiply path freezes while downstream holds
    assign mult_en = ~q_hold;

    zigzag_buffer zigzag_buffer_i (
        .clk      (clk),
        .resetn   (resetn),
        .di0      (di0),
        .di1      (di1),
        .di2      (di2),
        .di3      (di3),
        .di4      (di4),
        .di5      (di5),
        .di6      (di6),
        .di7      (di7),
        .di_valid (di_valid),
        .di_cnt   (di_cnt),
        .di_hold  (di_hold),
        .hold     (q_hold),
        .rd_en    (rd_en),
        .rd_pos0  (rd_pos0),
        .rd_pos1  (rd_pos1),
        .rd_data0 (rd_data0),
        .rd_data1 (rd_data1)
    );

    quant_tables quant_tables_i (
        .clk     (clk),
        .re      (rd_en),
        .pos0    (rd_pos0),
        .pos1    (rd_pos1),
        .factor0 (factor0),
        .factor1 (factor1)
    );

    always_ff @(posedge clk) begin
        if (!resetn) begin
            al_valid <= 1'b0;
        end else if (!q_hold) begin
            al_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            al_data0 <= rd_data0;
            al_data1 <= rd_data1;
        end
    end

    quant_mult quant_mult0_i (
        .clk       (clk),
        .resetn    (resetn),
        .en        (mult_en),
        .a         (al_data0),
        .b         (factor0),
        .in_valid  (al_valid),
        .p         (prod0),
        .out_valid (prod_valid)
    );

    // Multiplier 1 runs in lockstep with multiplier 0 and needs no valid of its own
    quant_mult quant_mult1_i (
        .clk       (clk),
        .resetn    (resetn),
        .en        (mult_en),
        .a         (al_data1),
        .b         (factor1),
        .in_valid  (al_valid),
        .p         (prod1),
        .out_valid ()
    );

    quant_result quant_result_i (
        .clk        (clk),
        .resetn     (resetn),
        .hold       (q_hold),
        .prod0      (prod0),
        .prod1      (prod1),
        .prod_valid (prod_valid),
        .q0         (q0),
        .q1         (q1),
        .q_valid    (q_valid),
        .q_cnt      (q_cnt)
    );

endmodule

/* tests/quant_tb.sv */
// Quantizer testbench with clock, reset, reference model, output monitor, directed tests and summary
module quant_tb
    import zigzag_pkg::*, quant_pkg::*;
();

    // Eight blocks at full rate, up to double under hold, plus idle gaps and reset
    localparam int n_blocks     = 8;
    localparam int block_cycles = row_size + pair_beats + 1 + mult_stages;
    localparam int max_cycles   = 5 * n_blocks * block_cycles + 200;

    logic                 clk;
    logic                 resetn;
    logic signed [dw-1:0] di0;
    logic signed [dw-1:0] di1;
    logic signed [dw-1:0] di2;
    logic signed [dw-1:0] di3;
    logic signed [dw-1:0] di4;
    logic signed [dw-1:0] di5;
    logic signed [dw-1:0] di6;
    logic signed [dw-1:0] di7;
    logic                 di_valid;
    logic [2:0]           di_cnt;
    logic                 di_hold;
    logic signed [qw-1:0] q0;
    logic signed [qw-1:0] q1;
    logic                 q_valid;
    logic                 q_hold;
    logic [4:0]           q_cnt;

    integer seed        = 32'h7b35_7688;
    int     cycles      = 0;
    int     errors      = 0;
    int     tests_ok    = 0;
    int     tests_bad   = 0;
    logic   hold_random = 1'b0;

    // Block being sent in raster order
    int blk [block_size];

    // Expected pairs in output order
    int exp_q0 [$];
    int exp_q1 [$];
    int exp_cnt [$];

    // Monitor state
    logic signed [qw-1:0] e0;
    logic signed [qw-1:0] e1;
    logic [4:0]           ec;
    logic                 held = 1'b0;
    logic signed [qw-1:0] held_q0;
    logic signed [qw-1:0] held_q1;
    logic [4:0]           held_cnt;
    logic                 held_valid;

    quant quant_i (
        .clk      (clk),
        .resetn   (resetn),
        .di0      (di0),
        .di1      (di1),
        .di2      (di2),
        .di3      (di3),
        .di4      (di4),
        .di5      (di5),
        .di6      (di6),
        .di7      (di7),
        .di_valid (di_valid),
        .di_cnt   (di_cnt),
        .di_hold  (di_hold),
        .q0       (q0),
        .q1       (q1),
        .q_valid  (q_valid),
        .q_hold   (q_hold),
        .q_cnt    (q_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles with %0d expected pairs never delivered",
                     cycles, exp_q0.size());
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Random downstream stall while enabled
    always @(posedge clk) begin
        if (hold_random) begin
            q_hold <= ($random(seed) % 2) != 0;
        end else begin
            q_hold <= 1'b0;
        end
    end

    task automatic check_field(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Divide by the table entry through its floored reciprocal, floor, clamp
    function automatic int expected_q(input int coef, input int pos);
        int factor;
        int scaled;
        factor = 4096 / int'(luma_table[pos]);
        scaled = (coef * factor) >>> 12;
        if (scaled > 1023) begin
            return 1023;
        end else if (scaled < -1024) begin
            return -1024;
        end
        return scaled;
    endfunction

    // Sampled mid-cycle; a pair shown here is taken at the next rising edge
    always @(negedge clk) begin
        if (resetn) begin
            if (held) begin
                check_field("q0 under hold", q0, held_q0);
                check_field("q1 under hold", q1, held_q1);
                check_field("q_cnt under hold", q_cnt, held_cnt);
                check_field("q_valid under hold", q_valid, held_valid);
            end
            if (q_valid && !q_hold) begin
                if (exp_q0.size() == 0) begin
                    $display("output pair with q_cnt %0d appeared with no block sent for it",
                             q_cnt);
                    errors++;
                end else begin
                    e0 = qw'(exp_q0.pop_front());
                    e1 = qw'(exp_q1.pop_front());
                    ec = 5'(exp_cnt.pop_front());
                    check_field("q_cnt", q_cnt, ec);
                    check_field("q0", q0, e0);
                    check_field("q1", q1, e1);
                end
            end
            held       = q_hold;
            held_q0    = q0;
            held_q1    = q1;
            held_cnt   = q_cnt;
            held_valid = q_valid;
        end else begin
            held = 1'b0;
        end
    end

    task automatic set_row(input int r);
        di0      <= dw'(blk[r*row_size + 0]);
        di1      <= dw'(blk[r*row_size + 1]);
        di2      <= dw'(blk[r*row_size + 2]);
        di3      <= dw'(blk[r*row_size + 3]);
        di4      <= dw'(blk[r*row_size + 4]);
        di5      <= dw'(blk[r*row_size + 5]);
        di6      <= dw'(blk[r*row_size + 6]);
        di7      <= dw'(blk[r*row_size + 7]);
        di_cnt   <= 3'(r);
        di_valid <= 1'b1;
    endtask

    task automatic fill_random();
        for (int p = 0; p < block_size; p++) begin
            blk[p] = $random(seed) % 2048;
        end
    endtask

    // Sends blk row by row and keeps each row on the bus until it is taken
    task automatic send_block();
        int         r;
        logic [5:0] pos0;
        logic [5:0] pos1;
        r = 0;
        @(posedge clk);
        set_row(0);
        while (r < row_size) begin
            @(negedge clk);
            if (!di_hold) begin
                r++;
            end
            @(posedge clk);
            if (r < row_size) begin
                set_row(r);
            end else begin
                di_valid <= 1'b0;
            end
        end
        for (int k = 0; k < pair_beats; k++) begin
            pos0 = de_zigzag(2*k);
            pos1 = de_zigzag(2*k + 1);
            exp_q0.push_back(expected_q(blk[pos0], pos0));
            exp_q1.push_back(expected_q(blk[pos1], pos1));
            exp_cnt.push_back(k);
        end
        // Last row switches the buffer to reading
        @(negedge clk);
        check_field("di_hold after last row", di_hold, 1'b1);
    endtask

    task automatic wait_drain();
        while (exp_q0.size() != 0) begin
            @(posedge clk);
        end
        // Quiet window in which any extra pair would be flagged
        repeat (8) @(posedge clk);
    endtask

    task automatic finish_test(input string name, input int err0);
        if (errors == err0) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - err0);
        end
    endtask

    task automatic reset_state();
        int err0;
        err0 = errors;
        check_field("di_hold", di_hold, 1'b0);
        check_field("q_valid", q_valid, 1'b0);
        check_field("q_cnt", q_cnt, 5'd0);
        repeat (16) @(posedge clk);
        finish_test("reset state", err0);
    endtask

    task automatic ramp_block();
        int err0;
        int n;
        err0 = errors;
        for (int p = 0; p < block_size; p++) begin
            blk[p] = 100 * p - 3200;
        end
        send_block();
        // di_hold spans exactly the read beats when nothing stalls
        n = 1;
        @(negedge clk);
        while (di_hold) begin
            n++;
            @(negedge clk);
        end
        check_field("di_hold cycles", n, pair_beats);
        wait_drain();
        finish_test("ramp block", err0);
    endtask

    task automatic back_to_back_blocks();
        int err0;
        err0 = errors;
        fill_random();
        send_block();
        fill_random();
        send_block();
        wait_drain();
        finish_test("back-to-back random blocks", err0);
    endtask

    task automatic output_backpressure();
        int err0;
        err0 = errors;
        hold_random <= 1'b1;
        fill_random();
        send_block();
        wait_drain();
        hold_random <= 1'b0;
        repeat (2) @(posedge clk);
        finish_test("random output hold", err0);
    endtask

    task automatic saturation_blocks();
        int err0;
        err0 = errors;
        for (int p = 0; p < block_size; p++) begin
            blk[p] = 16383;
        end
        send_block();
        for (int p = 0; p < block_size; p++) begin
            blk[p] = -16384;
        end
        send_block();
        wait_drain();
        finish_test("saturation", err0);
    endtask

    // Junk rows go out while the buffer reads and must leave no trace
    task automatic input_hold_rows();
        int err0;
        err0 = errors;
        fill_random();
        send_block();
        fill_random();
        for (int r = 0; r < row_size; r++) begin
            @(posedge clk);
            set_row(r);
            @(negedge clk);
            if (!di_hold) begin
                $display("di_hold fell before junk row %0d could be driven under it", r);
                errors++;
            end
        end
        @(posedge clk);
        di_valid <= 1'b0;
        fill_random();
        send_block();
        wait_drain();
        finish_test("rows ignored under di_hold", err0);
    endtask

    initial begin
        resetn   = 1'b0;
        di0      = '0;
        di1      = '0;
        di2      = '0;
        di3      = '0;
        di4      = '0;
        di5      = '0;
        di6      = '0;
        di7      = '0;
        di_valid = 1'b0;
        di_cnt   = '0;
        q_hold   = 1'b0;
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        reset_state();
        ramp_block();
        back_to_back_blocks();
        output_backpressure();
        saturation_blocks();
        input_hold_rows();
        $display("summary: %0d tests ok, %0d tests with errors, %0d check errors",
                 tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* build.f */
hdl/zigzag_pkg.sv
hdl/quant_pkg.sv
hdl/zigzag_buffer.sv
hdl/quant_tables.sv
hdl/quant_mult.sv
hdl/quant_result.sv
hdl/quant.sv
tests/quant_tb.sv
